// ==== src.f ====
src/rv_mem_pkg.sv
src/ex_mem_regs.sv
src/lsu.sv
src/data_ram.sv
src/mem_wb_regs.sv
src/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsystem
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem
	import rv_mem_pkg::*;
();

	logic    clk;
	logic    rst_n;
	logic    stall_in;
	ex_mem_t ex_in;
	wb_t     wb_out;

	integer          seed;
	logic [xlen-1:0] next_pc;
	logic [7:0]      model_mem [ram_words*8];  // byte image of the data RAM

	// expected writebacks in issue order and the edge that sampled each one
	wb_t         exp_q[$];
	int unsigned edge_q[$];
	wb_t         pend_wb;
	logic        pend_push;
	int unsigned edge_cnt = 0;

	wb_t         exp_wb = '0;
	int unsigned exp_lat = 0;
	logic        chk_valid = 1'b0;
	logic        spurious = 1'b0;
	int          err_cnt = 0;
	int          wb_cnt = 0;

	mem_subsystem dut0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall_i (stall_in),
		.ex_i    (ex_in),
		.wb_o    (wb_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] rnd32();
		return $random(seed);
	endfunction

	function automatic logic [xlen-1:0] rnd64();
		return {rnd32(), rnd32()};
	endfunction

	// spreads the word index over all 64 bits
	function automatic logic [xlen-1:0] fill_word(input int w);
		return 64'h9e37_79b9_7f4a_7c15 * 64'(w + 1);
	endfunction

	function automatic logic [xlen-1:0] model_load(input logic [11:0] addr,
		input mem_size_e size, input logic uns);
		logic [xlen-1:0] v;
		logic [11:0]     ba;
		logic            sign;
		int              n;
		n = 1 << size;
		v = '0;
		for (int i = 0; i < n; i++) begin
			ba = addr + 12'(i);
			v[i*8 +: 8] = model_mem[ba];  // little endian
		end
		case (size)
			size_byte: sign = v[7];
			size_half: sign = v[15];
			size_word: sign = v[31];
			default:   sign = 1'b0;
		endcase
		if (sign && !uns)
			v = v | (~64'd0 << (n * 8));
		return v;
	endfunction

	function automatic void model_store(input logic [11:0] addr, input mem_size_e size,
		input logic [xlen-1:0] data);
		logic [11:0] ba;
		for (int i = 0; i < (1 << size); i++) begin
			ba = addr + 12'(i);
			model_mem[ba] = data[i*8 +: 8];
		end
	endfunction

	function automatic ex_mem_t make_alu(input logic [xlen-1:0] res,
		input logic [reg_addr_w-1:0] rd, input logic wen, input logic brk);
		ex_mem_t e;
		e           = '0;
		e.alu_res   = res;
		e.reg_wen   = wen;
		e.reg_waddr = rd;
		e.ebreak    = brk;
		return e;
	endfunction

	function automatic ex_mem_t make_load(input logic [xlen-1:0] addr, input mem_size_e size,
		input logic uns, input logic [reg_addr_w-1:0] rd);
		ex_mem_t e;
		e               = make_alu(addr, rd, 1'b1, 1'b0);
		e.mem_op        = mem_load;
		e.mem_size      = size;
		e.load_unsigned = uns;
		return e;
	endfunction

	function automatic ex_mem_t make_store(input logic [xlen-1:0] addr, input mem_size_e size,
		input logic [xlen-1:0] data);
		ex_mem_t e;
		e            = make_alu(addr, 5'd0, 1'b0, 1'b0);
		e.mem_op     = mem_store;
		e.mem_size   = size;
		e.store_data = data;
		return e;
	endfunction

	// naturally aligned and mostly inside a small window so loads hit earlier stores
	function automatic logic [xlen-1:0] rand_addr(input mem_size_e size);
		logic [31:0] r;
		logic [8:0]  idx;
		logic [2:0]  off;
		r   = rnd32();
		idx = r[31] ? r[8:0] : {4'd0, r[4:0]};
		off = r[11:9] & ~((3'd1 << size) - 3'd1);
		return {52'd0, idx, off};
	endfunction

	task automatic issue(input ex_mem_t e);
		@(negedge clk);
		e.pc     = next_pc;
		next_pc  = next_pc + 64'd4;
		ex_in    = e;
		stall_in = 1'b0;
		pend_wb        = '0;
		pend_wb.wen    = 1'b1;
		pend_wb.waddr  = e.reg_waddr;
		pend_wb.pc     = e.pc;
		pend_wb.ebreak = e.ebreak;
		pend_wb.wdata  = (e.mem_op == mem_load) ?
			model_load(e.alu_res[11:0], e.mem_size, e.load_unsigned) : e.alu_res;
		pend_push = e.reg_wen;
		if (e.mem_op == mem_store)
			model_store(e.alu_res[11:0], e.mem_size, e.store_data);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			stall_in  = 1'b0;
			ex_in     = '0;
			pend_push = 1'b0;
		end
	endtask

	// junk on ex_in while stalled must never be sampled
	task automatic stall(input int n);
		repeat (n) begin
			@(negedge clk);
			stall_in  = 1'b1;
			ex_in     = make_store(rnd64(), size_double, rnd64());
			ex_in.reg_wen = 1'b1;
			ex_in.ebreak  = 1'b1;
			pend_push = 1'b0;
		end
	endtask

	task automatic print_counts();
		$display("writebacks checked %0d, errors %0d, still expected %0d",
			wb_cnt, err_cnt, exp_q.size());
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		print_counts();
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic drain(input int limit);
		int n;
		n = 0;
		do begin
			idle(1);
			@(posedge clk);  // pops happen at falling edges
			n++;
		end while (exp_q.size() != 0 && n < limit);
		if (exp_q.size() != 0)
			abort_run("timeout: expected writebacks never appeared on dut0.wb_o");
	endtask

	always @(posedge clk) begin
		edge_cnt = edge_cnt + 1;
		if (rst_n && pend_push) begin
			exp_q.push_back(pend_wb);
			edge_q.push_back(edge_cnt);
		end
	end

	// pop in mid cycle where wb_out has settled
	always @(negedge clk) begin
		chk_valid = 1'b0;
		spurious  = 1'b0;
		if (rst_n && wb_out.wen) begin
			if (exp_q.size() == 0) begin
				spurious = 1'b1;
			end else begin
				exp_wb    = exp_q.pop_front();
				exp_lat   = edge_cnt - edge_q.pop_front();
				chk_valid = 1'b1;
				wb_cnt    = wb_cnt + 1;
			end
		end
	end

	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n) !spurious)
	else begin
		err_cnt++;
		$display("writeback on dut0.wb_o with no instruction outstanding, pc %h",
			$sampled(wb_out.pc));
	end

	// on wb_o in the cycle after the edge that follows the sampling edge
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		chk_valid |-> exp_lat == 1)
	else begin
		err_cnt++;
		$display("** Error: dut0.wb_o.wen latency = %h edges, expected %h",
			$sampled(exp_lat), 32'd1);
	end

	a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
		chk_valid |-> wb_out.waddr == exp_wb.waddr)
	else begin
		err_cnt++;
		$display("** Error: dut0.wb_o.waddr = %h, expected %h",
			$sampled(wb_out.waddr), $sampled(exp_wb.waddr));
	end

	a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
		chk_valid |-> wb_out.wdata == exp_wb.wdata)
	else begin
		err_cnt++;
		$display("** Error: dut0.wb_o.wdata = %h, expected %h",
			$sampled(wb_out.wdata), $sampled(exp_wb.wdata));
	end

	a_pc: assert property (@(posedge clk) disable iff (!rst_n)
		chk_valid |-> wb_out.pc == exp_wb.pc && wb_out.ebreak == exp_wb.ebreak)
	else begin
		err_cnt++;
		$display("** Error: dut0.wb_o.pc/ebreak = %h/%h, expected %h/%h",
			$sampled(wb_out.pc), $sampled(wb_out.ebreak),
			$sampled(exp_wb.pc), $sampled(exp_wb.ebreak));
	end

	initial begin : stimulus
		logic [xlen-1:0] a;
		logic [31:0]     r;
		mem_size_e       sz;
		seed      = 32'h63b6_c91a;
		next_pc   = reset_pc;
		rst_n     = 1'b0;
		stall_in  = 1'b0;
		ex_in     = '0;
		pend_wb   = '0;
		pend_push = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		idle(6);  // wb_o must stay quiet here
		issue(make_alu(64'h0123_4567_89ab_cdef, 5'd3, 1'b1, 1'b0));
		issue(make_alu(64'hffff_ffff_ffff_fff0, 5'd4, 1'b1, 1'b1));
		issue(make_alu(64'h0000_0000_0000_0042, 5'd5, 1'b0, 1'b0));
		drain(10);

		for (int w = 0; w < ram_words; w++)
			issue(make_store(64'(w) << 3, size_double, fill_word(w)));

		// doubleword store with a load right behind it
		a = 64'h0000_0000_0000_0a08;
		issue(make_store(a, size_double, 64'hfedc_ba98_7654_3210));
		issue(make_load(a, size_double, 1'b0, 5'd5));
		idle(2);
		issue(make_load(a, size_double, 1'b1, 5'd6));
		drain(10);

		// sub-word merges checked word by word
		for (int s = 0; s < 3; s++) begin
			for (int off = 0; off < 8; off = off + (1 << s)) begin
				a = 64'((40 + s) * 8 + off);
				issue(make_store(a, mem_size_e'(s), rnd64()));
				issue(make_load(a & ~64'd7, size_double, 1'b0, 5'd1));
			end
		end
		for (int w = 40; w < 43; w++)
			for (int s = 0; s < 4; s++)
				for (int off = 0; off < 8; off = off + (1 << s))
					for (int u = 0; u < 2; u++)
						issue(make_load(64'(w * 8 + off), mem_size_e'(s), u[0], 5'd2));
		drain(10);

		// long stalls with each kind sitting in EX/MEM
		a = 64'h0000_0000_0000_0c14;
		issue(make_store(a, size_word, 64'h0000_0000_8765_4321));
		stall(4);
		issue(make_load(a & ~64'd7, size_double, 1'b0, 5'd7));
		stall(3);
		issue(make_alu(64'h0000_0000_0000_1234, 5'd8, 1'b1, 1'b1));
		stall(5);
		issue(make_load(a, size_word, 1'b0, 5'd9));
		drain(10);

		for (int i = 0; i < 300; i++) begin
			r  = rnd32();
			sz = mem_size_e'(r[1:0]);
			case (r[3:2])
				2'd0:    issue(make_store(rand_addr(sz), sz, rnd64()));
				2'd1:    issue(make_load(rand_addr(sz), sz, r[4], r[9:5]));
				2'd2:    issue(make_alu(rnd64(), r[9:5], 1'b1, r[13:10] == 4'd0));
				default: issue(make_alu(rnd64(), r[9:5], r[20], 1'b0));
			endcase
			if (r[17:15] == 3'd0)
				stall(1 + int'(r[19:18]));
		end
		drain(20);
		idle(2);

		print_counts();
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem
	import rv_mem_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  wire     stall_i,
	input  ex_mem_t ex_i,
	output wb_t     wb_o
);

	ex_mem_t               ex_q;
	logic                  held;
	logic [ram_addr_w-1:0] ram_addr;
	logic                  ram_we;
	logic [7:0]            ram_wmask;
	logic [xlen-1:0]       ram_wdata;
	mem_word_u             ram_rdata;
	mem_wb_t               entry;
	logic                  entry_valid;
	mem_wb_t               wb_entry;

	ex_mem_regs u_ex_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall_i (stall_i),
		.ex_i    (ex_i),
		.ex_o    (ex_q),
		.held_o  (held)
	);

	lsu u_lsu (
		.clk           (clk),
		.rst_n         (rst_n),
		.ex_i          (ex_q),
		.held_i        (held),
		.wb_entry_i    (wb_entry),
		.ram_addr_o    (ram_addr),
		.ram_we_o      (ram_we),
		.ram_wmask_o   (ram_wmask),
		.ram_wdata_o   (ram_wdata),
		.ram_rdata_i   (ram_rdata),
		.entry_o       (entry),
		.entry_valid_o (entry_valid),
		.wb_o          (wb_o)
	);

	data_ram u_ram (
		.clk     (clk),
		.addr_i  (ram_addr),
		.we_i    (ram_we),
		.wmask_i (ram_wmask),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	mem_wb_regs u_mem_wb (
		.clk           (clk),
		.rst_n         (rst_n),
		.entry_i       (entry),
		.entry_valid_i (entry_valid),
		.entry_o       (wb_entry)
	);

endmodule

`default_nettype wire

// ==== src/mem_wb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_regs
	import rv_mem_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  mem_wb_t entry_i,
	input  wire     entry_valid_i,
	output mem_wb_t entry_o
);

	mem_wb_t entry_d;

	// held or empty entries become a bubble
	always_comb begin
		entry_d = entry_i;
		if (!entry_valid_i) begin
			entry_d.reg_wen = 1'b0;
			entry_d.ebreak  = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			entry_o    <= '0;
			entry_o.pc <= reset_pc;
		end else begin
			entry_o <= entry_d;
		end
	end

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram
	import rv_mem_pkg::*;
(
	input  wire                   clk,
	input  wire  [ram_addr_w-1:0] addr_i,
	input  wire                   we_i,
	input  wire  [7:0]            wmask_i,  // one bit per byte lane
	input  wire  [xlen-1:0]       wdata_i,
	output mem_word_u             rdata_o
);

	mem_word_u mem [ram_words];

	// byte-masked write
	always_ff @(posedge clk) begin
		if (we_i) begin
			for (int i = 0; i < 8; i++) begin
				if (wmask_i[i])
					mem[addr_i].bytes[i] <= wdata_i[i*8 +: 8];
			end
		end
	end

	// registered read, old data on a same-address write
	always_ff @(posedge clk) begin
		rdata_o <= mem[addr_i];
	end

	// every store carries at least one byte
	a_mask_nonzero: assert property (
		@(posedge clk) we_i |-> wmask_i != 8'h00
	) else $error("data_ram: write with empty mask at word %h", addr_i);

endmodule

`default_nettype wire

// ==== src/lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu
	import rv_mem_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst_n,
	// stage registers
	input  ex_mem_t               ex_i,
	input  wire                   held_i,
	input  mem_wb_t               wb_entry_i,
	// RAM side
	output logic [ram_addr_w-1:0] ram_addr_o,
	output logic                  ram_we_o,
	output logic [7:0]            ram_wmask_o,
	output logic [xlen-1:0]       ram_wdata_o,
	input  mem_word_u             ram_rdata_i,
	// towards MEM/WB and writeback
	output mem_wb_t               entry_o,
	output logic                  entry_valid_o,
	output wb_t                   wb_o
);

	logic [2:0]      byte_off;
	logic [7:0]      size_mask;
	logic            aligned;
	logic [2:0]      rd_off;
	logic [7:0]      lane_b;
	logic [15:0]     lane_h;
	logic [31:0]     lane_w;
	logic            sext;
	logic [xlen-1:0] load_data;

	assign byte_off = ex_i.alu_res[2:0];

	// a held entry was executed on its first cycle already
	assign entry_valid_o = !held_i && (ex_i.mem_op != mem_none || ex_i.reg_wen);

	// store side
	always_comb begin
		case (ex_i.mem_size)
			size_byte: begin
				size_mask = 8'h01;
				aligned   = 1'b1;
			end
			size_half: begin
				size_mask = 8'h03;
				aligned   = !byte_off[0];
			end
			size_word: begin
				size_mask = 8'h0f;
				aligned   = byte_off[1:0] == 2'b00;
			end
			default: begin
				size_mask = 8'hff;
				aligned   = byte_off == 3'b000;
			end
		endcase
	end

	assign ram_addr_o  = ex_i.alu_res[ram_addr_w+2:3];  // word address
	assign ram_we_o    = entry_valid_o && ex_i.mem_op == mem_store;
	assign ram_wmask_o = size_mask << byte_off;
	assign ram_wdata_o = ex_i.store_data << {byte_off, 3'b000};  // move into lane

	// entry for MEM/WB
	always_comb begin
		entry_o               = '0;
		entry_o.pc            = ex_i.pc;
		entry_o.alu_res       = ex_i.alu_res;
		entry_o.reg_wen       = ex_i.reg_wen;
		entry_o.reg_waddr     = ex_i.reg_waddr;
		entry_o.ebreak        = ex_i.ebreak;
		entry_o.is_load       = ex_i.mem_op == mem_load;
		entry_o.mem_size      = ex_i.mem_size;
		entry_o.load_unsigned = ex_i.load_unsigned;
		entry_o.byte_off      = byte_off;
	end

	// load side, RAM word arrives together with the MEM/WB entry
	assign rd_off = wb_entry_i.byte_off;
	assign lane_b = ram_rdata_i.bytes[rd_off];
	assign lane_h = ram_rdata_i.halves[rd_off[2:1]];
	assign lane_w = rd_off[2] ? {ram_rdata_i.halves[3], ram_rdata_i.halves[2]}
		: {ram_rdata_i.halves[1], ram_rdata_i.halves[0]};
	assign sext   = !wb_entry_i.load_unsigned;

	always_comb begin
		case (wb_entry_i.mem_size)
			size_byte: load_data = {{(xlen-8){sext & lane_b[7]}}, lane_b};
			size_half: load_data = {{(xlen-16){sext & lane_h[15]}}, lane_h};
			size_word: load_data = {{(xlen-32){sext & lane_w[31]}}, lane_w};
			default:   load_data = ram_rdata_i;  // full doubleword
		endcase
	end

	always_comb begin
		wb_o        = '0;
		wb_o.wen    = wb_entry_i.reg_wen;
		wb_o.waddr  = wb_entry_i.reg_waddr;
		wb_o.wdata  = wb_entry_i.is_load ? load_data : wb_entry_i.alu_res;
		wb_o.pc     = wb_entry_i.pc;
		wb_o.ebreak = wb_entry_i.ebreak;
	end

	// no misaligned handling in this pipeline
	a_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		(entry_valid_o && ex_i.mem_op != mem_none) |-> aligned
	) else $error("lsu: misaligned access addr=%h size=%0d", ex_i.alu_res, ex_i.mem_size);

endmodule

`default_nettype wire

// ==== src/ex_mem_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_mem_regs
	import rv_mem_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  wire     stall_i,   // freeze the stage
	input  ex_mem_t ex_i,
	output ex_mem_t ex_o,
	output logic    held_o     // entry was already seen by the memory stage
);

	// stage register
	// on a stall the entry stays put and held_o goes high so that
	// the memory stage does not repeat a store or a writeback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_o    <= '0;
			ex_o.pc <= reset_pc;
			held_o  <= 1'b0;
		end else if (stall_i) begin
			held_o <= 1'b1;  // contents kept
		end else begin
			ex_o   <= ex_i;
			held_o <= 1'b0;
		end
	end

	// control fields feed the RAM write enable and the writeback valid
	a_ctrl_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown({ex_o.reg_wen, ex_o.mem_op, held_o})
	) else $error("ex_mem_regs: unknown control, reg_wen=%b mem_op=%b held=%b",
		ex_o.reg_wen, ex_o.mem_op, held_o);

endmodule

`default_nettype wire

// ==== src/rv_mem_pkg.sv ====
`default_nettype none

package rv_mem_pkg;

	localparam int xlen       = 64;
	localparam int reg_addr_w = 5;
	localparam int ram_words  = 512;  // 4 KiB of data memory
	localparam int ram_addr_w = 9;

	localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

	typedef enum logic [1:0] {
		mem_none  = 2'd0,
		mem_load  = 2'd1,
		mem_store = 2'd2
	} mem_op_e;

	// access size, log2 of the byte count
	typedef enum logic [1:0] {
		size_byte   = 2'd0,
		size_half   = 2'd1,
		size_word   = 2'd2,
		size_double = 2'd3
	} mem_size_e;

	// results handed over by the execute stage
	typedef struct packed {
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       alu_res;     // result or byte address
		logic [xlen-1:0]       store_data;
		logic                  reg_wen;
		logic [reg_addr_w-1:0] reg_waddr;
		mem_op_e               mem_op;
		mem_size_e             mem_size;
		logic                  load_unsigned;
		logic                  ebreak;
	} ex_mem_t;

	// what writeback still needs once the RAM read is under way
	typedef struct packed {
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       alu_res;
		logic                  reg_wen;
		logic [reg_addr_w-1:0] reg_waddr;
		logic                  ebreak;
		logic                  is_load;
		mem_size_e             mem_size;
		logic                  load_unsigned;
		logic [2:0]            byte_off;    // lane inside the 64-bit word
	} mem_wb_t;

	typedef struct packed {
		logic                  wen;
		logic [reg_addr_w-1:0] waddr;
		logic [xlen-1:0]       wdata;
		logic [xlen-1:0]       pc;
		logic                  ebreak;
	} wb_t;

	// one RAM word, viewed per byte or per halfword
	typedef union packed {
		logic [7:0][7:0]  bytes;
		logic [3:0][15:0] halves;  // words are halves 3:2 and 1:0
	} mem_word_u;

endpackage

`default_nettype wire
